// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_sdram_subsys -f list.f -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: list.f
verilog/sdram_pkg.sv
verilog/sdram_bus_if.sv
verilog/req_fifo.sv
verilog/sdram_ctrl.sv
verilog/sdram_model.sv
verilog/sdram_subsys.sv
testbench/sdram_chk.sv
testbench/tb_sdram_subsys.sv

// File: testbench/sdram_chk.sv
`timescale 1ns/100ps

module sdram_chk (
    input logic                 clk,
    input sdram_pkg::cmd_t      cmd,
    input sdram_pkg::bank_t     ba,
    input logic [3:0]           bank_active,
    input logic                 lat3,
    input logic                 rd_en
);
    import sdram_pkg::*;

    // Raised by any failing assertion, watched by the testbench
    logic proto_err = 1'b0;

    // Column access needs an open bank
    a_rw_open: assert property (@(posedge clk) (cmd == READ || cmd == WRITE) |-> bank_active[ba])
        else begin
            $error("READ or WRITE to a closed bank");
            proto_err = 1'b1;
        end

    // No ACTIVE on top of an open row
    a_act_closed: assert property (@(posedge clk) (cmd == ACTIVE) |-> !bank_active[ba])
        else begin
            $error("ACTIVE to a bank that is already open");
            proto_err = 1'b1;
        end

    // Refresh needs every bank precharged
    a_ref_idle: assert property (@(posedge clk) (cmd == REFRESH) |-> (bank_active == 4'b0000))
        else begin
            $error("REFRESH with a bank still open");
            proto_err = 1'b1;
        end

    // Read data shows up at the programmed CAS latency
    a_rd_due: assert property (@(posedge clk)
        (lat3 ? $past(cmd == READ, 3) : $past(cmd == READ, 2)) |-> rd_en)
        else begin
            $error("Read data missing at the CAS latency");
            proto_err = 1'b1;
        end

    // No read data without a READ that latency earlier
    a_rd_only: assert property (@(posedge clk)
        rd_en |-> (lat3 ? $past(cmd == READ, 3) : $past(cmd == READ, 2)))
        else begin
            $error("Read data driven with no matching READ");
            proto_err = 1'b1;
        end

endmodule

bind sdram_model sdram_chk i_chk (
    .clk         (clk),
    .cmd         (bus.cmd),
    .ba          (bus.ba),
    .bank_active (bank_active),
    .lat3        (lat3),
    .rd_en       (bus.rd_en)
);

// File: testbench/tb_sdram_subsys.sv
`timescale 1ns/100ps

module tb_sdram_subsys;
    import sdram_pkg::*;

    localparam int NUM_RANDOM  = 64;
    // Longer than the refresh interval
    localparam int IDLE_GAP    = 250;
    // Cycles allowed for the last responses to come back
    localparam int DRAIN_LIMIT = 100;
    // Init, about 30 cycles per request worst case, idle gap, drain
    localparam int CYCLE_LIMIT = 200 + 30 * (NUM_RANDOM + 100) + IDLE_GAP + DRAIN_LIMIT;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_write;
    addr_t       req_addr;
    data_t       req_wdata;
    mask_t       req_mask;
    logic        req_ready;
    logic        rsp_valid;
    data_t       rsp_data;

    logic [15:0] lfsr;
    // Reference memory over 4 banks, 4 rows, 8 columns
    data_t       ref_mem [128];
    logic        written [128];
    data_t       exp_q [$];
    string       name_q [$];
    int          rd_count;
    int          rsp_count;
    int          cycle_cnt;
    logic        saw_backpressure;

    sdram_subsys #(
        .CAS_LAT          (3),
        .REFRESH_INTERVAL (200),
        .FIFO_DEPTH       (4)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_mask  (req_mask),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input logic [1:0] bank, input logic [1:0] row,
                                        input logic [2:0] col);
        return {bank, 6'd0, row, 5'd0, col};
    endfunction

    function automatic logic [6:0] ref_idx(input addr_t addr);
        return {addr[17:16], addr[9:8], addr[2:0]};
    endfunction

    // Model of what the memory holds once the request is accepted
    task automatic record(input string name, input logic wr, input addr_t addr,
                          input data_t data, input mask_t mask);
        logic [6:0] idx;
        idx = ref_idx(addr);
        if (wr) begin
            if (!mask[0]) ref_mem[idx][7:0] = data[7:0];
            if (!mask[1]) ref_mem[idx][15:8] = data[15:8];
            if (mask == 2'b00) written[idx] = 1'b1;
        end else begin
            exp_q.push_back(ref_mem[idx]);
            name_q.push_back(name);
            rd_count++;
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send(input string name, input logic wr, input addr_t addr,
                        input data_t data, input mask_t mask);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        req_mask  = mask;
        @(negedge clk);
        while (!req_ready) begin
            saw_backpressure = 1'b1;
            @(negedge clk);
        end
        record(name, wr, addr, data, mask);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // Responses checked mid cycle in request order
    always @(negedge clk) begin
        assert (!i_dut.i_model.i_chk.proto_err)
            else stop_on_error("SDRAM protocol assertion fired");
        if (rst_n === 1'b1 && rsp_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("read response arrived with no read pending");
            end else begin
                assert (rsp_data == exp_q[0])
                    else report_mismatch(name_q[0], exp_q[0], rsp_data);
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                rsp_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) stop_on_error("timeout, the run took too many cycles");
    end

    initial begin
        logic [1:0] bank;
        logic [1:0] row;
        logic [2:0] col;
        logic       wr;
        data_t      data;
        mask_t      mask;
        addr_t      addr;
        clk              = 1'b0;
        rst_n            = 1'b0;
        req_valid        = 1'b0;
        req_write        = 1'b0;
        req_addr         = '0;
        req_wdata        = '0;
        req_mask         = '0;
        lfsr             = 16'd93;
        rd_count         = 0;
        rsp_count        = 0;
        cycle_cnt        = 0;
        saw_backpressure = 1'b0;
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = '0;
            written[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Stream during init fills the FIFO
        for (int i = 0; i < 8; i++) begin
            send("init_stream", 1'b1, make_addr(2'd0, 2'd0, 3'(i)), 16'(rand_bits(16)), 2'b00);
        end

        // Masked writes keep the masked byte
        for (int b = 0; b < 4; b++) begin
            addr = make_addr(2'(b), 2'(b), 3'(b + 1));
            send("write_mask", 1'b1, addr, 16'(rand_bits(16)), 2'b00);
            send("write_mask", 1'b1, addr, 16'(rand_bits(16)), 2'b01);
            send("write_mask", 1'b0, addr, '0, 2'b00);
            send("write_mask", 1'b1, addr, 16'(rand_bits(16)), 2'b10);
            send("write_mask", 1'b0, addr, '0, 2'b00);
        end

        // Rows 0 and 3 of bank 1 in turn, every access a miss
        for (int i = 0; i < 4; i++) begin
            send("row_miss", 1'b1, make_addr(2'd1, 2'd0, 3'(i)), 16'(rand_bits(16)), 2'b00);
            send("row_miss", 1'b1, make_addr(2'd1, 2'd3, 3'(i)), 16'(rand_bits(16)), 2'b00);
        end
        for (int i = 0; i < 4; i++) begin
            send("row_miss", 1'b0, make_addr(2'd1, 2'd0, 3'(i)), '0, 2'b00);
            send("row_miss", 1'b0, make_addr(2'd1, 2'd3, 3'(i)), '0, 2'b00);
        end
        // Open row hits, reads in flight together
        for (int i = 0; i < 4; i++) begin
            send("row_hit", 1'b0, make_addr(2'd1, 2'd3, 3'(i)), '0, 2'b00);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            bank = 2'(rand_bits(2));
            row  = 2'(rand_bits(2));
            col  = 3'(rand_bits(3));
            wr   = 1'(rand_bits(1));
            data = 16'(rand_bits(16));
            mask = 2'(rand_bits(2));
            addr = make_addr(bank, row, col);
            // First access to an address is always a full write
            if (!written[ref_idx(addr)]) send("random_mix", 1'b1, addr, data, 2'b00);
            else if (wr) send("random_mix", 1'b1, addr, data, mask);
            else send("random_mix", 1'b0, addr, '0, 2'b00);
        end

        // Idle long enough for a refresh, then read back
        repeat (IDLE_GAP) @(posedge clk);
        #1;
        for (int i = 0; i < 128; i += 5) begin
            if (written[i]) begin
                addr = make_addr(2'(i >> 5), 2'(i >> 3), 3'(i));
                send("refresh", 1'b0, addr, '0, 2'b00);
            end
        end

        // Last reads still in flight, bounded wait
        for (int w = 0; w < DRAIN_LIMIT && exp_q.size() != 0; w++) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (saw_backpressure) else stop_on_error("req_ready never went low");
        if (rsp_count != rd_count) begin
            stop_on_error("number of responses differs from number of reads accepted");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: verilog/req_fifo.sv
`timescale 1ns/100ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  sdram_pkg::req_t  in_data,
    output logic             in_ready,
    output logic             out_valid,
    output sdram_pkg::req_t  out_data,
    input  logic             out_ready
);
    import sdram_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Circular buffer storage
    req_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One bit wider than the pointers to tell full from empty
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // No bypass when full
    assign in_ready  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own for a power of two depth
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            // Count holds when both happen
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

// File: verilog/sdram_bus_if.sv
`timescale 1ns/100ps

interface sdram_bus_if;
    import sdram_pkg::*;

    // Command and address, registered in the controller
    cmd_t                 cmd;
    bank_t                ba;
    logic [ADDR_BITS-1:0] a;
    mask_t                dqm;

    // Split data bus
    data_t                wdata;
    data_t                rdata;
    // High while the device drives rdata
    logic                 rd_en;

    modport ctrl (
        output cmd, ba, a, dqm, wdata,
        input  rdata
    );

    modport dev (
        input  cmd, ba, a, dqm, wdata,
        output rdata, rd_en
    );

endinterface

// File: verilog/sdram_ctrl.sv
`timescale 1ns/100ps

module sdram_ctrl #(
    parameter int CAS_LAT          = 3,
    parameter int REFRESH_INTERVAL = 200
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  sdram_pkg::req_t  req_data,
    output logic             req_ready,
    output logic             rsp_valid,
    output sdram_pkg::data_t rsp_data,
    sdram_bus_if.ctrl        bus
);
    import sdram_pkg::*;

    // Fixed timing in clock cycles
    localparam int T_RP        = 2;
    localparam int T_RCD       = 2;
    localparam int T_RC        = 6;
    localparam int T_MRD       = 2;
    localparam int INIT_CYCLES = 100;
    localparam int WAIT_W      = $clog2(INIT_CYCLES);
    localparam int REF_W       = $clog2(REFRESH_INTERVAL);

    // Wait counter loads, WAIT state itself adds one cycle
    localparam logic [WAIT_W-1:0] W_RP  = WAIT_W'(T_RP - 2);
    localparam logic [WAIT_W-1:0] W_RCD = WAIT_W'(T_RCD - 2);
    localparam logic [WAIT_W-1:0] W_RC  = WAIT_W'(T_RC - 2);
    localparam logic [WAIT_W-1:0] W_MRD = WAIT_W'(T_MRD - 2);
    localparam logic [REF_W-1:0]  REF_LAST = REF_W'(REFRESH_INTERVAL - 1);

    // Burst length 1, sequential, CAS latency from the parameter
    localparam logic [ADDR_BITS-1:0] MODE_WORD = ADDR_BITS'(CAS_LAT << MODE_CL_LSB);
    localparam logic [ADDR_BITS-1:0] A10_MASK  = ADDR_BITS'(1 << A10_BIT);

    ctrl_state_t          state;
    ctrl_state_t          after_state;
    logic [WAIT_W-1:0]    wait_cnt;
    logic [REF_W-1:0]     ref_cnt;
    logic                 ref_due;

    // Open row tracking per bank
    logic [NUM_BANKS-1:0] bank_open;
    row_t                 open_row [NUM_BANKS];

    // Request being served, live input while in IDLE
    req_t                 cur_req;
    req_t                 sel_req;
    logic                 sel_write;
    addr_t                sel_addr;
    data_t                sel_wdata;
    mask_t                sel_mask;
    bank_t                sel_bank;
    row_t                 sel_row;
    col_t                 sel_col;

    logic                 accept;
    logic                 hit;
    logic                 pre_all;
    logic                 issue_acc;
    logic                 issue_act;
    logic                 issue_pre;
    cmd_t                 nxt_cmd;
    logic [ADDR_BITS-1:0] nxt_a;
    // One tag per READ in flight
    logic [CAS_LAT:0]     rd_tags;

    assign req_ready = (state == IDLE) && !ref_due;
    assign accept    = req_valid && req_ready;

    assign sel_req = (state == IDLE) ? req_data : cur_req;
    assign {sel_write, sel_addr, sel_wdata, sel_mask} = sel_req;
    assign {sel_bank, sel_row, sel_col} = sel_addr;

    assign hit = bank_open[sel_bank] && (open_row[sel_bank] == sel_row);

    // Row hit goes out straight from IDLE
    assign issue_acc = (state == ACCESS) || (accept && hit);
    // Closed bank activates straight from IDLE too
    assign issue_act = (state == ACT) || (accept && !bank_open[sel_bank]);
    assign pre_all   = (state == INIT_PRE) || (state == PRE);
    // Row miss closes only its own bank
    assign issue_pre = pre_all || (accept && !hit && bank_open[sel_bank]);

    always_comb begin
        nxt_cmd = NOP;
        nxt_a   = ADDR_BITS'(sel_col);
        if (issue_acc) begin
            nxt_cmd = sel_write ? WRITE : READ;
        end else if (issue_act) begin
            nxt_cmd = ACTIVE;
            nxt_a   = ADDR_BITS'(sel_row);
        end else if (issue_pre) begin
            nxt_cmd = PRECHARGE;
            nxt_a   = pre_all ? A10_MASK : '0;
        end else if (state == REF) begin
            nxt_cmd = REFRESH;
        end else if (state == INIT_MODE) begin
            nxt_cmd = LOAD_MODE;
            nxt_a   = MODE_WORD;
        end
    end

    // Main FSM and bank state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= INIT_WAIT;
            after_state <= IDLE;
            wait_cnt    <= WAIT_W'(INIT_CYCLES - 1);
            bank_open   <= '0;
            bus.cmd     <= NOP;
        end else begin
            bus.cmd <= nxt_cmd;
            if (issue_pre && pre_all) bank_open <= '0;
            else if (issue_pre) bank_open[sel_bank] <= 1'b0;
            else if (issue_act) bank_open[sel_bank] <= 1'b1;
            case (state)
                INIT_WAIT: begin
                    if (wait_cnt == '0) state <= INIT_PRE;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                INIT_PRE: begin
                    wait_cnt    <= W_RP;
                    after_state <= INIT_MODE;
                    state       <= WAIT;
                end
                INIT_MODE: begin
                    wait_cnt    <= W_MRD;
                    after_state <= IDLE;
                    state       <= WAIT;
                end
                IDLE: begin
                    // Refresh wins over a waiting request
                    if (ref_due) begin
                        state <= PRE;
                    end else if (accept && !hit) begin
                        wait_cnt    <= bank_open[sel_bank] ? W_RP : W_RCD;
                        after_state <= bank_open[sel_bank] ? ACT : ACCESS;
                        state       <= WAIT;
                    end
                end
                PRE: begin
                    wait_cnt    <= W_RP;
                    after_state <= REF;
                    state       <= WAIT;
                end
                ACT: begin
                    wait_cnt    <= W_RCD;
                    after_state <= ACCESS;
                    state       <= WAIT;
                end
                ACCESS: state <= IDLE;
                REF: begin
                    wait_cnt    <= W_RC;
                    after_state <= IDLE;
                    state       <= WAIT;
                end
                WAIT: begin
                    if (wait_cnt == '0) state <= after_state;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                default: state <= INIT_WAIT;
            endcase
        end
    end

    // Command payload and open rows
    always_ff @(posedge clk) begin
        bus.ba    <= sel_bank;
        bus.a     <= nxt_a;
        bus.dqm   <= (issue_acc && sel_write) ? sel_mask : '0;
        bus.wdata <= sel_wdata;
        if (accept) cur_req <= req_data;
        if (issue_act) open_row[sel_bank] <= sel_row;
    end

    // Refresh interval timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ref_cnt <= '0;
            ref_due <= 1'b0;
        end else begin
            if (state == REF) ref_due <= 1'b0;
            if (ref_cnt == REF_LAST) begin
                ref_cnt <= '0;
                ref_due <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

    // Read capture CAS_LAT+1 cycles after the READ leaves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_tags   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rd_tags   <= {rd_tags[CAS_LAT-1:0], issue_acc && !sel_write};
            rsp_valid <= rd_tags[CAS_LAT];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_tags[CAS_LAT]) rsp_data <= bus.rdata;
    end

endmodule

// File: verilog/sdram_model.sv
`timescale 1ns/100ps

module sdram_model (
    input logic      clk,
    sdram_bus_if.dev bus
);
    import sdram_pkg::*;

    localparam int MEM_BITS = BANK_BITS + ROW_BITS + COL_BITS;

    // Whole array, indexed by {bank, row, col}
    data_t                mem [2**MEM_BITS];

    // Bank state
    logic [NUM_BANKS-1:0] bank_active;
    row_t                 active_row [NUM_BANKS];

    // CAS latency code from the mode register
    logic [2:0]           cas_code;
    logic                 lat3;

    logic [MEM_BITS-1:0]  idx;
    logic                 wr_en;
    logic                 rd_hit;

    // Read latency pipe, stage 0 feeds the outputs
    logic [1:0]           rd_vld;
    data_t                rd_data [2];

    // Column from the bus, row from the bank's open row
    assign idx    = {bus.ba, active_row[bus.ba], bus.a[COL_BITS-1:0]};
    assign wr_en  = (bus.cmd == WRITE) && bank_active[bus.ba];
    assign rd_hit = (bus.cmd == READ) && bank_active[bus.ba];
    // Latency 2 and 3 only
    assign lat3   = (cas_code == 3'd3);

    // Mode and bank state decode
    always_ff @(posedge clk) begin
        case (bus.cmd)
            LOAD_MODE: begin
                // Burst length field ignored, always one word
                cas_code <= bus.a[MODE_CL_LSB +: 3];
            end
            ACTIVE: begin
                bank_active[bus.ba] <= 1'b1;
                active_row[bus.ba]  <= bus.a[ROW_BITS-1:0];
            end
            PRECHARGE: begin
                // a10 closes every bank
                if (bus.a[A10_BIT]) bank_active <= '0;
                else bank_active[bus.ba] <= 1'b0;
            end
            default: begin
                // INHIBIT NOP READ WRITE REFRESH leave bank state alone
            end
        endcase
    end

    // Write lands on the decode edge, unmasked bytes only
    always_ff @(posedge clk) begin
        if (wr_en && !bus.dqm[0]) mem[idx][7:0] <= bus.wdata[7:0];
        if (wr_en && !bus.dqm[1]) mem[idx][15:8] <= bus.wdata[15:8];
    end

    // Data is fetched at decode and delayed by CAS latency minus one
    always_ff @(posedge clk) begin
        rd_vld[1]  <= rd_hit && lat3;
        rd_data[1] <= mem[idx];
        if (rd_hit && !lat3) begin
            rd_vld[0]  <= 1'b1;
            rd_data[0] <= mem[idx];
        end else begin
            rd_vld[0]  <= rd_vld[1];
            rd_data[0] <= rd_data[1];
        end
        bus.rd_en <= rd_vld[0];
        bus.rdata <= rd_data[0];
    end

endmodule

// File: verilog/sdram_pkg.sv
package sdram_pkg;

    // Geometry of the small simulated device
    localparam int BANK_BITS = 2;
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 8;
    localparam int ADDR_BITS = 13;
    localparam int NUM_BANKS = 1 << BANK_BITS;

    // Address bus fields
    // Auto precharge on READ/WRITE, all banks on PRECHARGE
    localparam int A10_BIT     = 10;
    // CAS latency field of the mode register
    localparam int MODE_CL_LSB = 4;

    typedef logic [15:0]          data_t;
    // Set bit masks its byte
    typedef logic [1:0]           mask_t;
    typedef logic [BANK_BITS-1:0] bank_t;
    typedef logic [ROW_BITS-1:0]  row_t;
    typedef logic [COL_BITS-1:0]  col_t;
    // User address is {bank, row, col}
    typedef logic [BANK_BITS+ROW_BITS+COL_BITS-1:0] addr_t;

    // Packed request {write, addr, wdata, mask}
    localparam int REQ_BITS = 1 + $bits(addr_t) + $bits(data_t) + $bits(mask_t);
    typedef logic [REQ_BITS-1:0] req_t;

    // Encoded as {cs, ras, cas, we}, all active low
    typedef enum logic [3:0] {
        INHIBIT   = 4'b1111,
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001,
        LOAD_MODE = 4'b0000
    } cmd_t;

    typedef enum logic [3:0] {
        INIT_WAIT, INIT_PRE, INIT_MODE, IDLE, PRE, ACT, ACCESS, REF, WAIT
    } ctrl_state_t;

endpackage

// File: verilog/sdram_subsys.sv
`timescale 1ns/100ps

module sdram_subsys #(
    parameter int CAS_LAT          = 3,
    parameter int REFRESH_INTERVAL = 200,
    parameter int FIFO_DEPTH       = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_write,
    input  sdram_pkg::addr_t   req_addr,
    input  sdram_pkg::data_t   req_wdata,
    input  sdram_pkg::mask_t   req_mask,
    output logic               req_ready,
    output logic               rsp_valid,
    output sdram_pkg::data_t   rsp_data
);
    import sdram_pkg::*;

    // Packed request into and out of the FIFO
    req_t req_packed;
    req_t fifo_data;
    logic fifo_valid;
    logic ctrl_ready;

    sdram_bus_if i_bus ();

    assign req_packed = {req_write, req_addr, req_wdata, req_mask};

    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_data   (req_packed),
        .in_ready  (req_ready),
        .out_valid (fifo_valid),
        .out_data  (fifo_data),
        .out_ready (ctrl_ready)
    );

    sdram_ctrl #(
        .CAS_LAT          (CAS_LAT),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (fifo_valid),
        .req_data  (fifo_data),
        .req_ready (ctrl_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .bus       (i_bus.ctrl)
    );

    // Device learns its latency from the mode register
    sdram_model i_model (
        .clk (clk),
        .bus (i_bus.dev)
    );

endmodule
